//--- Makefile
SRCS := $(wildcard src/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdecode_tb: $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module decode_tb \
		-Mdir obj_dir -o Vdecode_tb

run: obj_dir/Vdecode_tb
	./obj_dir/Vdecode_tb | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
src/rv_decode_pkg.sv
src/instr_store.sv
src/result_store.sv
src/rv_decoder.sv
src/decode_ctrl.sv
src/axil_regs.sv
src/decode_top.sv
testbench/decode_checker.sv
testbench/decode_tb.sv

//--- src/axil_regs.sv
// AXI4-Lite slave with ctrl and status registers and the instruction, info and immediate windows
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
  input  logic                     global_bus,
  input  logic                     rst,
  input  rv_decode_pkg::axil_req_t req,
  output rv_decode_pkg::axil_rsp_t rsp,
  input  logic                     busy,
  input  logic                     done,
  output logic                     start,
  output rv_decode_pkg::idx_t      last,
  output logic                     instr_we,
  output rv_decode_pkg::idx_t      instr_windex,
  output rv_decode_pkg::instr_t    instr_wdata,
  output rv_decode_pkg::idx_t      result_rindex,
  input  rv_decode_pkg::decoded_t  result_rdata
);

  logic wr_hs, rd_hs;
  logic wr_ctrl, wr_status, wr_instr, wr_err;
  logic rd_ctrl, rd_status, rd_err;
  logic bvalid, rvalid;
  logic [1:0] bresp, rresp;
  logic [rv_decode_pkg::xlen-1:0] rdata, rd_value;

  assign wr_hs = req.awvalid && req.wvalid && !bvalid;
  assign rd_hs = req.arvalid && !rvalid;

  assign wr_ctrl = (req.awaddr[7:2] == rv_decode_pkg::addr_ctrl[7:2]);
  assign wr_status = (req.awaddr[7:2] == rv_decode_pkg::addr_status[7:2]);
  assign wr_instr = (req.awaddr[7:6] == rv_decode_pkg::addr_instr_base[7:6]);
  assign wr_err = (busy && (wr_ctrl || wr_instr))
                  || (req.awaddr[7:6] == 2'b00 && !wr_ctrl && !wr_status);

  assign rd_ctrl = (req.araddr[7:2] == rv_decode_pkg::addr_ctrl[7:2]);
  assign rd_status = (req.araddr[7:2] == rv_decode_pkg::addr_status[7:2]);

  always_comb begin
    rd_value = '0;
    rd_err = 1'b0;
    case (req.araddr[7:6])
      2'b00: begin
        if (rd_ctrl) rd_value = {28'd0, last};
        else if (rd_status) rd_value = {30'd0, done, busy};
        else rd_err = 1'b1;
      end
      2'b01: rd_value = '0;  // Instruction window is write-only
      2'b10: rd_value = {6'd0, result_rdata.instr_name, result_rdata.instr_type,
                         result_rdata.flags, result_rdata.regs};
      default: rd_value = result_rdata.immediate;
    endcase
  end

  always_ff @(posedge global_bus) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      start <= 1'b0;
      last <= '0;
    end else begin
      start <= 1'b0;
      if (wr_hs) begin
        bvalid <= 1'b1;
        if (wr_ctrl && !busy) begin
          last <= req.wdata[3:0];
          start <= req.wdata[8];  // One-cycle pulse
        end
      end else if (req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_hs) rvalid <= 1'b1;
      else if (req.rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge global_bus) begin
    if (wr_hs) bresp <= wr_err ? rv_decode_pkg::resp_slverr : rv_decode_pkg::resp_okay;
    if (rd_hs) begin
      rdata <= rd_value;
      rresp <= rd_err ? rv_decode_pkg::resp_slverr : rv_decode_pkg::resp_okay;
    end
  end

  assign instr_we = wr_hs && wr_instr && !busy;
  assign instr_windex = req.awaddr[5:2];
  assign instr_wdata = req.wdata;
  assign result_rindex = req.araddr[5:2];  // Combinational store read

  assign rsp.awready = wr_hs;
  assign rsp.wready = wr_hs;
  assign rsp.bresp = bresp;
  assign rsp.bvalid = bvalid;
  assign rsp.arready = !rvalid;
  assign rsp.rdata = rdata;
  assign rsp.rresp = rresp;
  assign rsp.rvalid = rvalid;

endmodule

`default_nettype wire

//--- src/decode_ctrl.sv
// Control FSM sequencing fetch, decode and result write-back with busy and done
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
  input  logic                global_bus,
  input  logic                rst,
  input  logic                start,
  input  rv_decode_pkg::idx_t last,
  output rv_decode_pkg::idx_t fetch_index,
  output logic                hold,
  output logic                result_we,
  output rv_decode_pkg::idx_t result_index,
  output logic                busy,
  output logic                done
);

  rv_decode_pkg::ctrl_state_t state;
  rv_decode_pkg::idx_t fetch;
  logic pipe_valid;
  rv_decode_pkg::idx_t pipe_index;

  always_ff @(posedge global_bus) begin
    if (rst) begin
      state <= rv_decode_pkg::idle;
      fetch <= '0;
      done <= 1'b0;
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= (state == rv_decode_pkg::run);  // Matches decoder latency
      case (state)
        rv_decode_pkg::idle: begin
          if (start) begin
            state <= rv_decode_pkg::run;
            fetch <= '0;
            done <= 1'b0;
          end
        end
        rv_decode_pkg::run: begin
          if (fetch == last) begin
            state <= rv_decode_pkg::drain;
          end else begin
            fetch <= fetch + 1'b1;
          end
        end
        rv_decode_pkg::drain: begin  // Final record is written this cycle
          state <= rv_decode_pkg::idle;
          done <= 1'b1;
        end
        default: state <= rv_decode_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    pipe_index <= fetch;
  end

  assign fetch_index = fetch;
  assign hold = (state != rv_decode_pkg::run);
  assign result_we = pipe_valid;
  assign result_index = pipe_index;
  assign busy = (state != rv_decode_pkg::idle);

endmodule

`default_nettype wire

//--- src/decode_top.sv
// Decode front end top level connecting the register slave, FSM, stores and decoder
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic                     global_bus,
  input  logic                     rst,
  input  rv_decode_pkg::axil_req_t req,
  output rv_decode_pkg::axil_rsp_t rsp
);

  logic start, busy, done, hold, instr_we, result_we;
  rv_decode_pkg::idx_t last, instr_windex, result_rindex, fetch_index, result_index;
  rv_decode_pkg::instr_t instr_wdata, instr;
  rv_decode_pkg::decoded_t result_rdata, decoded;

  axil_regs i_regs (
    .global_bus(global_bus), .rst(rst), .req(req), .rsp(rsp),
    .busy(busy), .done(done), .start(start), .last(last),
    .instr_we(instr_we), .instr_windex(instr_windex), .instr_wdata(instr_wdata),
    .result_rindex(result_rindex), .result_rdata(result_rdata)
  );

  decode_ctrl i_ctrl (
    .global_bus(global_bus), .rst(rst), .start(start), .last(last),
    .fetch_index(fetch_index), .hold(hold), .result_we(result_we),
    .result_index(result_index), .busy(busy), .done(done)
  );

  instr_store i_instr_store (
    .global_bus(global_bus), .we(instr_we), .windex(instr_windex),
    .wdata(instr_wdata), .rindex(fetch_index), .rdata(instr)
  );

  rv_decoder i_decoder (
    .global_bus(global_bus), .instr(instr), .hold(hold), .decoded(decoded)
  );

  result_store i_result_store (
    .global_bus(global_bus), .we(result_we), .windex(result_index),
    .wdata(decoded), .rindex(result_rindex), .rdata(result_rdata)
  );

endmodule

`default_nettype wire

//--- src/instr_store.sv
// Instruction store, 16 words, host write port and async read for the control block
`timescale 1ns/1ps
`default_nettype none

module instr_store (
  input  logic                  global_bus,
  input  logic                  we,
  input  rv_decode_pkg::idx_t   windex,
  input  rv_decode_pkg::instr_t wdata,
  input  rv_decode_pkg::idx_t   rindex,
  output rv_decode_pkg::instr_t rdata
);

  rv_decode_pkg::instr_t mem [rv_decode_pkg::store_depth];

  always_ff @(posedge global_bus) begin
    if (we) begin
      mem[windex] <= wdata;
    end
  end

  assign rdata = mem[rindex];  // Same-cycle fetch

endmodule

`default_nettype wire

//--- src/result_store.sv
// Result store, 16 decoded records, written by the control block and read by the host
`timescale 1ns/1ps
`default_nettype none

module result_store (
  input  logic                    global_bus,
  input  logic                    we,
  input  rv_decode_pkg::idx_t     windex,
  input  rv_decode_pkg::decoded_t wdata,
  input  rv_decode_pkg::idx_t     rindex,
  output rv_decode_pkg::decoded_t rdata
);

  rv_decode_pkg::decoded_t mem [rv_decode_pkg::store_depth];

  always_ff @(posedge global_bus) begin
    if (we) begin
      mem[windex] <= wdata;
    end
  end

  assign rdata = mem[rindex];  // Host read data path

endmodule

`default_nettype wire

//--- src/rv_decode_pkg.sv
// Decode front end localparams, width types, name/type/state enums, record and AXI4-Lite structs
`default_nettype none

package rv_decode_pkg;

  localparam int xlen = 32;
  localparam int store_depth = 16;

  typedef logic [$clog2(store_depth)-1:0] idx_t;
  typedef logic [31:0] instr_t;
  typedef logic [xlen-1:0] imm_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [7:0] axil_addr_t;

  localparam axil_addr_t addr_ctrl = 8'h00;  // [3:0] count-1, [8] start
  localparam axil_addr_t addr_status = 8'h04;  // [0] busy, [1] done
  localparam axil_addr_t addr_instr_base = 8'h40;
  localparam axil_addr_t addr_info_base = 8'h80;
  localparam axil_addr_t addr_imm_base = 8'hC0;

  localparam logic [1:0] resp_okay = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  // Zero encoding is unknown so a cleared record reads as unknown
  typedef enum logic [5:0] {
    rv_unknown = 6'd0,
    rv_lui, rv_auipc, rv_jal, rv_jalr,
    rv_beq, rv_bne, rv_blt, rv_bge, rv_bltu, rv_bgeu,
    rv_lb, rv_lh, rv_lw, rv_lbu, rv_lhu, rv_sb, rv_sh, rv_sw,
    rv_addi, rv_slti, rv_sltiu, rv_xori, rv_ori, rv_andi, rv_slli, rv_srli, rv_srai,
    rv_add, rv_sub, rv_sll, rv_slt, rv_sltu, rv_xor, rv_srl, rv_sra, rv_or, rv_and,
    rv_ecall, rv_ebreak
  } instr_name_t;

  typedef enum logic [1:0] {none = 2'd0, al, ls, br} instr_type_t;

  typedef enum logic [1:0] {idle = 2'd0, run, drain} ctrl_state_t;

  typedef struct packed {
    reg_idx_t rd;
    reg_idx_t rs_1;
    reg_idx_t rs_2;
  } reg_fields_t;

  typedef struct packed {
    logic writes;
    logic jumps;
    logic uses_imm;
  } decode_flags_t;

  // Immediate on top so the low 26 bits are the info word
  typedef struct packed {
    imm_t          immediate;
    instr_name_t   instr_name;
    instr_type_t   instr_type;
    decode_flags_t flags;
    reg_fields_t   regs;
  } decoded_t;

  typedef struct packed {
    axil_addr_t      awaddr;
    logic            awvalid;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;
    logic            wvalid;
    logic            bready;
    axil_addr_t      araddr;
    logic            arvalid;
    logic            rready;
  } axil_req_t;

  typedef struct packed {
    logic            awready;
    logic            wready;
    logic [1:0]      bresp;
    logic            bvalid;
    logic            arready;
    logic [xlen-1:0] rdata;
    logic [1:0]      rresp;
    logic            rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- src/rv_decoder.sv
// Registered RV32I decoder giving name, type, flags, register fields and immediate
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic                    global_bus,
  input  rv_decode_pkg::instr_t   instr,
  input  logic                    hold,
  output rv_decode_pkg::decoded_t decoded
);

  logic [2:0] funct3;
  rv_decode_pkg::imm_t imm_i, imm_s, imm_b, imm_u, imm_j, shamt;
  rv_decode_pkg::reg_fields_t regs_i, regs_r, regs_s, regs_u;
  rv_decode_pkg::decoded_t nxt;

  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign shamt = {27'd0, instr[24:20]};

  assign regs_i = {instr[11:7], instr[19:15], 5'd0};
  assign regs_r = {instr[11:7], instr[19:15], instr[24:20]};
  assign regs_s = {5'd0, instr[19:15], instr[24:20]};
  assign regs_u = {instr[11:7], 10'd0};

  always_comb begin
    nxt = '0;
    case (instr[4:2])
      3'b000: begin
        case (instr[6:5])
          2'b00: begin  // LOAD
            nxt.instr_type = rv_decode_pkg::ls;
            nxt.flags.writes = 1'b1;
            nxt.regs = regs_i;
            nxt.immediate = imm_i;
            case (funct3)
              3'b000: nxt.instr_name = rv_decode_pkg::rv_lb;
              3'b001: nxt.instr_name = rv_decode_pkg::rv_lh;
              3'b010: nxt.instr_name = rv_decode_pkg::rv_lw;
              3'b100: nxt.instr_name = rv_decode_pkg::rv_lbu;
              3'b101: nxt.instr_name = rv_decode_pkg::rv_lhu;
              default: nxt.instr_name = rv_decode_pkg::rv_unknown;
            endcase
          end
          2'b01: begin  // STORE
            nxt.instr_type = rv_decode_pkg::ls;
            nxt.regs = regs_s;
            nxt.immediate = imm_s;
            case (funct3)
              3'b000: nxt.instr_name = rv_decode_pkg::rv_sb;
              3'b001: nxt.instr_name = rv_decode_pkg::rv_sh;
              3'b010: nxt.instr_name = rv_decode_pkg::rv_sw;
              default: nxt.instr_name = rv_decode_pkg::rv_unknown;
            endcase
          end
          2'b11: begin  // BRANCH
            nxt.instr_type = rv_decode_pkg::br;
            nxt.flags.jumps = 1'b1;
            nxt.regs = regs_s;
            nxt.immediate = imm_b;
            case (funct3)
              3'b000: nxt.instr_name = rv_decode_pkg::rv_beq;
              3'b001: nxt.instr_name = rv_decode_pkg::rv_bne;
              3'b100: nxt.instr_name = rv_decode_pkg::rv_blt;
              3'b101: nxt.instr_name = rv_decode_pkg::rv_bge;
              3'b110: nxt.instr_name = rv_decode_pkg::rv_bltu;
              3'b111: nxt.instr_name = rv_decode_pkg::rv_bgeu;
              default: nxt.instr_name = rv_decode_pkg::rv_unknown;
            endcase
          end
          default: nxt.instr_name = rv_decode_pkg::rv_unknown;
        endcase
      end
      3'b001: begin  // JALR
        if (instr[6:5] == 2'b11) begin
          nxt = '{imm_i, rv_decode_pkg::rv_jalr, rv_decode_pkg::br, 3'b110, regs_i};
        end
      end
      3'b011: begin
        if (instr[6:5] == 2'b00) begin  // FENCE treated as a plain ADDI
          nxt.instr_name = rv_decode_pkg::rv_addi;
          nxt.instr_type = rv_decode_pkg::al;
        end else if (instr[6:5] == 2'b11) begin  // JAL
          nxt = '{imm_j, rv_decode_pkg::rv_jal, rv_decode_pkg::br, 3'b110, regs_u};
        end
      end
      3'b100: begin
        nxt.instr_type = rv_decode_pkg::al;
        case (instr[6:5])
          2'b00: begin  // OP-IMM
            nxt.flags = 3'b101;
            nxt.regs = regs_i;
            nxt.immediate = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : imm_i;
            case (funct3)
              3'b000: nxt.instr_name = rv_decode_pkg::rv_addi;
              3'b001: nxt.instr_name = rv_decode_pkg::rv_slli;
              3'b010: nxt.instr_name = rv_decode_pkg::rv_slti;
              3'b011: nxt.instr_name = rv_decode_pkg::rv_sltiu;
              3'b100: nxt.instr_name = rv_decode_pkg::rv_xori;
              3'b101: nxt.instr_name = instr[30] ? rv_decode_pkg::rv_srai : rv_decode_pkg::rv_srli;
              3'b110: nxt.instr_name = rv_decode_pkg::rv_ori;
              default: nxt.instr_name = rv_decode_pkg::rv_andi;
            endcase
          end
          2'b01: begin  // OP
            nxt.flags.writes = 1'b1;
            nxt.regs = regs_r;
            case (funct3)
              3'b000: nxt.instr_name = instr[30] ? rv_decode_pkg::rv_sub : rv_decode_pkg::rv_add;
              3'b001: nxt.instr_name = rv_decode_pkg::rv_sll;
              3'b010: nxt.instr_name = rv_decode_pkg::rv_slt;
              3'b011: nxt.instr_name = rv_decode_pkg::rv_sltu;
              3'b100: nxt.instr_name = rv_decode_pkg::rv_xor;
              3'b101: nxt.instr_name = instr[30] ? rv_decode_pkg::rv_sra : rv_decode_pkg::rv_srl;
              3'b110: nxt.instr_name = rv_decode_pkg::rv_or;
              default: nxt.instr_name = rv_decode_pkg::rv_and;
            endcase
          end
          2'b11: nxt.instr_name = instr[20] ? rv_decode_pkg::rv_ebreak : rv_decode_pkg::rv_ecall;
          default: nxt.instr_name = rv_decode_pkg::rv_unknown;
        endcase
      end
      3'b101: begin  // AUIPC and LUI
        if (!instr[6]) begin
          nxt.instr_name = instr[5] ? rv_decode_pkg::rv_lui : rv_decode_pkg::rv_auipc;
          nxt.instr_type = rv_decode_pkg::al;
          nxt.flags.writes = 1'b1;
          nxt.regs = regs_u;
          nxt.immediate = imm_u;
        end
      end
      default: nxt.instr_name = rv_decode_pkg::rv_unknown;
    endcase
    // Non-32-bit encodings (incl. the zero word) and unmatched cases give an all-zero record
    if (instr[1:0] != 2'b11 || nxt.instr_name == rv_decode_pkg::rv_unknown) begin
      nxt = '0;
    end
  end

  always_ff @(posedge global_bus) begin
    if (!hold) begin
      decoded <= nxt;
    end
  end

endmodule

`default_nettype wire

//--- testbench/decode_checker.sv
// Bound assertions on the AXI4-Lite responses and the decode control block
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
  input logic                     global_bus,
  input logic                     rst,
  input rv_decode_pkg::axil_req_t req,
  input rv_decode_pkg::axil_rsp_t rsp,
  input logic                     start,
  input logic                     busy,
  input logic                     done,
  input rv_decode_pkg::idx_t      last,
  input logic                     result_we
);

  logic [4:0] remain;  // Cycles left until done is due
  int failures = 0;

  always_ff @(posedge global_bus) begin
    if (rst) begin
      remain <= '0;
    end else if (start && !busy) begin
      remain <= {1'b0, last} + 5'd2;
    end else if (remain != '0) begin
      remain <= remain - 5'd1;
    end
  end

  a_bvalid_hold: assert property (@(posedge global_bus) disable iff (rst)
    rsp.bvalid && !req.bready |=> rsp.bvalid) else begin
    failures++;
    $error("bvalid dropped early");
  end
  a_rvalid_hold: assert property (@(posedge global_bus) disable iff (rst)
    rsp.rvalid && !req.rready |=> rsp.rvalid) else begin
    failures++;
    $error("rvalid dropped early");
  end
  a_busy_done: assert property (@(posedge global_bus) disable iff (rst)
    !(busy && done)) else begin
    failures++;
    $error("busy and done both high");
  end
  a_we_busy: assert property (@(posedge global_bus) disable iff (rst)
    result_we |-> busy) else begin
    failures++;
    $error("result write outside a run");
  end
  a_done_time: assert property (@(posedge global_bus) disable iff (rst)
    remain == 5'd1 |-> !done ##1 done) else begin
    failures++;
    $error("done not on time");
  end

endmodule

// Hooked into the top level, where the ctrl and register signals meet
bind decode_top decode_checker i_checker (
  .global_bus(global_bus), .rst(rst), .req(req), .rsp(rsp), .start(start),
  .busy(busy), .done(done), .last(last), .result_we(result_we)
);

`default_nettype wire

//--- testbench/decode_tb.sv
// Testbench with clock, reset, AXI4-Lite host tasks, decode vector table and readback checks
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

  typedef struct packed {
    rv_decode_pkg::instr_t        word;
    rv_decode_pkg::instr_name_t   name;
    rv_decode_pkg::instr_type_t   kind;
    rv_decode_pkg::decode_flags_t flags;
    rv_decode_pkg::reg_idx_t      rd;
    rv_decode_pkg::reg_idx_t      rs_1;
    rv_decode_pkg::reg_idx_t      rs_2;
    rv_decode_pkg::imm_t          imm;
  } vector_t;

  localparam int wait_limit = 60;

  logic global_bus;
  logic rst;
  rv_decode_pkg::axil_req_t req;
  rv_decode_pkg::axil_rsp_t rsp;
  vector_t vec [20];
  logic [15:0] lfsr;
  int errors;
  int checks;
  int tests;
  int errors_before;

  decode_top i_dut (.global_bus(global_bus), .rst(rst), .req(req), .rsp(rsp));

  initial begin
    global_bus = 1'b0;
    forever #5 global_bus = ~global_bus;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
  endfunction

  function automatic int random_delay();
    int d;
    d = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
    return d;
  endfunction

  function automatic rv_decode_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd,
                                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_decode_pkg::instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic rv_decode_pkg::instr_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv_decode_pkg::instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  function automatic rv_decode_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  task automatic set_row(input int i, input rv_decode_pkg::instr_t w,
                         input rv_decode_pkg::instr_name_t n, input rv_decode_pkg::instr_type_t k,
                         input logic [2:0] f, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [31:0] imm);
    vec[i] = {w, n, k, f, rd, rs1, rs2, imm};
  endtask

  task automatic abort_run(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called and returns on a falling edge
  task automatic axil_write(input rv_decode_pkg::axil_addr_t addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int t;
    req.awaddr = addr;
    req.wdata = data;
    req.wstrb = 4'hF;
    req.awvalid = 1'b1;
    req.wvalid = 1'b1;
    t = 0;
    #1;
    while (!rsp.awready) begin
      @(negedge global_bus);
      #1;
      t++;
      if (t > wait_limit) abort_run("no write address handshake");
    end
    assert (rsp.wready) else begin
      $display("Write data not accepted together with the address at %0t", $time);
      errors++;
    end
    @(negedge global_bus);
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    t = 0;
    while (!rsp.bvalid) begin
      @(negedge global_bus);
      t++;
      if (t > wait_limit) abort_run("no write response");
    end
    repeat (random_delay()) @(negedge global_bus);
    resp = rsp.bresp;
    req.bready = 1'b1;
    @(negedge global_bus);
    req.bready = 1'b0;
    assert (!rsp.bvalid) else begin
      $display("Write response repeated at %0t", $time);
      errors++;
    end
  endtask

  task automatic axil_read(input rv_decode_pkg::axil_addr_t addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int t;
    req.araddr = addr;
    req.arvalid = 1'b1;
    t = 0;
    #1;
    while (!rsp.arready) begin
      @(negedge global_bus);
      #1;
      t++;
      if (t > wait_limit) abort_run("no read address handshake");
    end
    @(negedge global_bus);
    req.arvalid = 1'b0;
    t = 0;
    while (!rsp.rvalid) begin
      @(negedge global_bus);
      t++;
      if (t > wait_limit) abort_run("no read data");
    end
    repeat (random_delay()) @(negedge global_bus);
    data = rsp.rdata;
    resp = rsp.rresp;
    req.rready = 1'b1;
    @(negedge global_bus);
    req.rready = 1'b0;
    assert (!rsp.rvalid) else begin
      $display("Read response repeated at %0t", $time);
      errors++;
    end
  endtask

  task automatic load_rows(input int first, input int count);
    logic [1:0] resp;
    for (int i = 0; i < count; i++) begin
      axil_write(8'h40 + 8'(4 * i), vec[first + i].word, resp);
      check_value("instruction write resp", {30'd0, resp}, 32'd0);
    end
  endtask

  task automatic start_run(input int count);
    logic [1:0] resp;
    axil_write(8'h00, 32'h100 | 32'(count - 1), resp);
    check_value("start write resp", {30'd0, resp}, 32'd0);
  endtask

  task automatic wait_done();
    logic [31:0] data;
    logic [1:0] resp;
    int t;
    t = 0;
    data = '0;
    while (!data[1]) begin
      axil_read(8'h04, data, resp);
      t++;
      if (t > wait_limit) abort_run("decoder never reported done");
    end
    check_value("status when done", data, 32'h2);
  endtask

  // Entries below split come from row base, the rest from the first program
  task automatic check_results(input int split, input int base);
    logic [31:0] info;
    logic [31:0] imm;
    logic [1:0] resp;
    vector_t v;
    for (int i = 0; i < 16; i++) begin
      v = (i < split) ? vec[base + i] : vec[i];
      axil_read(8'h80 + 8'(4 * i), info, resp);
      check_value($sformatf("entry %0d info", i), info,
                  {6'd0, v.name, v.kind, v.flags, v.rd, v.rs_1, v.rs_2});
      axil_read(8'hC0 + 8'(4 * i), imm, resp);
      check_value($sformatf("entry %0d immediate", i), imm, v.imm);
    end
  endtask

  task automatic report_test(input string label);
    tests++;
    $display("%-28s %0d errors", label, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0] resp;
    rst = 1'b1;
    req = '0;
    lfsr = 16'd19;
    errors = 0;
    checks = 0;
    tests = 0;
    errors_before = 0;
    set_row(0, enc_i(12'hFFC, 5'd2, 3'b010, 5'd5, 7'h03), rv_decode_pkg::rv_lw,
            rv_decode_pkg::ls, 3'b100, 5'd5, 5'd2, 5'd0, 32'hFFFFFFFC);
    set_row(1, enc_s(12'hFF8, 5'd7, 5'd3, 3'b010), rv_decode_pkg::rv_sw,
            rv_decode_pkg::ls, 3'b000, 5'd0, 5'd3, 5'd7, 32'hFFFFFFF8);
    set_row(2, enc_b(13'h1FF0, 5'd2, 5'd1, 3'b000), rv_decode_pkg::rv_beq,
            rv_decode_pkg::br, 3'b010, 5'd0, 5'd1, 5'd2, 32'hFFFFFFF0);
    set_row(3, enc_j(21'h1FF800, 5'd1), rv_decode_pkg::rv_jal,
            rv_decode_pkg::br, 3'b110, 5'd1, 5'd0, 5'd0, 32'hFFFFF800);
    set_row(4, enc_i(12'd12, 5'd4, 3'b000, 5'd3, 7'h67), rv_decode_pkg::rv_jalr,
            rv_decode_pkg::br, 3'b110, 5'd3, 5'd4, 5'd0, 32'd12);
    set_row(5, {20'hABCDE, 5'd9, 7'h37}, rv_decode_pkg::rv_lui,
            rv_decode_pkg::al, 3'b100, 5'd9, 5'd0, 5'd0, 32'hABCDE000);
    set_row(6, {20'h12345, 5'd10, 7'h17}, rv_decode_pkg::rv_auipc,
            rv_decode_pkg::al, 3'b100, 5'd10, 5'd0, 5'd0, 32'h12345000);
    set_row(7, enc_i(12'hFFF, 5'd12, 3'b000, 5'd11, 7'h13), rv_decode_pkg::rv_addi,
            rv_decode_pkg::al, 3'b101, 5'd11, 5'd12, 5'd0, 32'hFFFFFFFF);
    set_row(8, enc_i(12'd31, 5'd2, 3'b001, 5'd1, 7'h13), rv_decode_pkg::rv_slli,
            rv_decode_pkg::al, 3'b101, 5'd1, 5'd2, 5'd0, 32'd31);
    set_row(9, enc_i(12'd5, 5'd4, 3'b101, 5'd3, 7'h13), rv_decode_pkg::rv_srli,
            rv_decode_pkg::al, 3'b101, 5'd3, 5'd4, 5'd0, 32'd5);
    set_row(10, enc_i(12'h407, 5'd6, 3'b101, 5'd5, 7'h13), rv_decode_pkg::rv_srai,
            rv_decode_pkg::al, 3'b101, 5'd5, 5'd6, 5'd0, 32'd7);
    set_row(11, enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), rv_decode_pkg::rv_add,
            rv_decode_pkg::al, 3'b100, 5'd1, 5'd2, 5'd3, 32'd0);
    set_row(12, enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd4), rv_decode_pkg::rv_sub,
            rv_decode_pkg::al, 3'b100, 5'd4, 5'd5, 5'd6, 32'd0);
    set_row(13, enc_r(7'h20, 5'd9, 5'd8, 3'b101, 5'd7), rv_decode_pkg::rv_sra,
            rv_decode_pkg::al, 3'b100, 5'd7, 5'd8, 5'd9, 32'd0);
    set_row(14, 32'h00000073, rv_decode_pkg::rv_ecall,
            rv_decode_pkg::al, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);
    set_row(15, 32'h00100073, rv_decode_pkg::rv_ebreak,
            rv_decode_pkg::al, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);
    set_row(16, 32'h00000000, rv_decode_pkg::rv_unknown,
            rv_decode_pkg::none, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);
    set_row(17, enc_i(12'd5, 5'd1, 3'b011, 5'd2, 7'h03), rv_decode_pkg::rv_unknown,
            rv_decode_pkg::none, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);
    set_row(18, 32'h0000007F, rv_decode_pkg::rv_unknown,
            rv_decode_pkg::none, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);
    set_row(19, 32'h0FF0000F, rv_decode_pkg::rv_addi,
            rv_decode_pkg::al, 3'b000, 5'd0, 5'd0, 5'd0, 32'd0);  // FENCE
    repeat (2) @(posedge global_bus);
    @(negedge global_bus);
    rst = 1'b0;

    load_rows(0, 16);
    start_run(16);
    axil_read(8'h04, data, resp);
    check_value("status while busy", data, 32'h1);
    axil_write(8'h00, 32'h101, resp);
    check_value("ctrl write while busy", {30'd0, resp}, 32'd2);
    axil_write(8'h54, 32'h0, resp);
    check_value("instr write while busy", {30'd0, resp}, 32'd2);
    wait_done();
    axil_read(8'h00, data, resp);
    check_value("ctrl after blocked write", data, 32'd15);
    report_test("busy protection");
    check_results(0, 0);
    report_test("full program");

    axil_read(8'h08, data, resp);
    check_value("unmapped read 0x08", {30'd0, resp}, 32'd2);
    axil_read(8'h3C, data, resp);
    check_value("unmapped read 0x3C", {30'd0, resp}, 32'd2);
    axil_write(8'h0C, 32'h1, resp);
    check_value("unmapped write 0x0C", {30'd0, resp}, 32'd2);
    report_test("unmapped addresses");

    load_rows(16, 4);
    // Entry 4 gets a new word past the end of the run, its old record must stay
    axil_write(8'h50, vec[16].word, resp);
    check_value("entry 4 write resp", {30'd0, resp}, 32'd0);
    start_run(4);
    wait_done();
    check_results(4, 16);
    report_test("short program");

    // Rerun over the whole store shows the blocked write left it intact
    axil_write(8'h50, vec[4].word, resp);
    check_value("entry 4 restore resp", {30'd0, resp}, 32'd0);
    start_run(16);
    wait_done();
    check_results(4, 16);
    report_test("instruction store intact");

    errors += i_dut.i_checker.failures;
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
